// ==== biquad_top.f ====
design/filter_pkg.sv
design/ctrl_pkg.sv
design/coef_decode.sv
design/biquad_execute.sv
design/result_round.sv
design/biquad_top.sv
verif/biquad_checker.sv
verif/biquad_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the biquad testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module biquad_tb \
    -f biquad_top.f -o biquad_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/biquad_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "All tests passed" && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

// ==== verif/biquad_tb.sv ====
`timescale 1ns/100ps

module biquad_tb
    import filter_pkg::*, ctrl_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY = 7;
    localparam int LATENCY_LIMIT = 12;
    localparam int SPACING = 8;
    localparam int N_BYPASS = 16;
    localparam int N_FIR = 6;
    localparam int N_SAT = 2;
    localparam int N_IIR = 20;
    localparam int N_IMPULSE = 6;
    localparam int N_MIX = 6;
    localparam int N_OVERRUN = 3;
    localparam int TOTAL_SAMPLES = N_BYPASS + N_FIR + N_SAT + 2 * N_IIR
                                 + 2 * N_IMPULSE + N_MIX + N_OVERRUN;
    localparam int MARGIN_NS = 3000;
    localparam int WATCHDOG_NS = TOTAL_SAMPLES * SPACING * CLK_PERIOD + MARGIN_NS;
    localparam logic signed [SAMPLE_WIDTH-1:0] DROP_SAMPLE = -16'sd12345;

    logic                           clk;
    logic                           reset;
    logic                           cmd_valid;
    cmd_op_t                        cmd_op;
    logic signed [COEF_WIDTH-1:0]   cmd_data;
    logic                           in_valid;
    logic signed [SAMPLE_WIDTH-1:0] in_sample;
    logic signed [SAMPLE_WIDTH-1:0] out_sample;
    logic                           out_valid;
    logic                           out_sat;
    logic                           busy;
    logic                           overrun;

    integer seed;

    // reference model state
    longint m_b0;
    longint m_b1;
    longint m_b2;
    longint m_a1;
    longint m_a2;
    longint m_x1;
    longint m_x2;
    longint m_y1;
    longint m_y2;
    logic   m_bypass;

    biquad_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .out_sample (out_sample),
        .out_valid  (out_valid),
        .out_sat    (out_sat),
        .busy       (busy),
        .overrun    (overrun)
    );

    bind biquad_top biquad_checker i_checker (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .busy      (busy),
        .out_valid (out_valid),
        .overrun   (overrun)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    task automatic check_sample(input string what,
                                input logic signed [SAMPLE_WIDTH-1:0] actual,
                                input logic signed [SAMPLE_WIDTH-1:0] expected);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, actual, expected));
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic check_latency(input string what, input int actual, input int expected);
        if (actual != expected) begin
            report_mismatch($sformatf("%s is %0d cycles, expected %0d", what, actual, expected));
        end
    endtask

    // direct form I with round half up, shift and clamp
    function automatic void predict(input logic signed [SAMPLE_WIDTH-1:0] x,
                                    output logic signed [SAMPLE_WIDTH-1:0] y,
                                    output logic sat);
        longint xs;
        longint acc;
        longint r;
        longint hi;
        longint lo;
        xs = x;
        hi = (64'sd1 <<< (SAMPLE_WIDTH - 1)) - 1;
        lo = -(64'sd1 <<< (SAMPLE_WIDTH - 1));
        if (m_bypass) begin
            acc = xs <<< COEF_FRAC;
        end else begin
            acc = m_b0 * xs + m_b1 * m_x1 + m_b2 * m_x2 - m_a1 * m_y1 - m_a2 * m_y2;
        end
        r = (acc + (64'sd1 <<< (COEF_FRAC - 1))) >>> COEF_FRAC;
        sat = 1'b0;
        if (r > hi) begin
            r = hi;
            sat = 1'b1;
        end else if (r < lo) begin
            r = lo;
            sat = 1'b1;
        end
        y = r[SAMPLE_WIDTH-1:0];
        // saturated output is the y history
        m_x2 = m_x1;
        m_x1 = xs;
        m_y2 = m_y1;
        m_y1 = r;
    endfunction

    function automatic logic signed [SAMPLE_WIDTH-1:0] random_sample();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[SAMPLE_WIDTH-1:0];
    endfunction

    // narrow range keeps coefficients within +-2
    function automatic logic signed [COEF_WIDTH-1:0] random_coef(input logic full_range);
        logic [31:0]                  rnd;
        logic signed [COEF_WIDTH-3:0] narrow;
        rnd = $random(seed);
        narrow = rnd[COEF_WIDTH-3:0];
        if (full_range) begin
            return rnd[COEF_WIDTH-1:0];
        end else begin
            return narrow;
        end
    endfunction

    task automatic send_cmd(input cmd_op_t op, input logic signed [COEF_WIDTH-1:0] data);
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_data = data;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cmd_op = op_nop;
        cmd_data = '0;
    endtask

    task automatic set_coefs(input logic signed [COEF_WIDTH-1:0] b0,
                             input logic signed [COEF_WIDTH-1:0] b1,
                             input logic signed [COEF_WIDTH-1:0] b2,
                             input logic signed [COEF_WIDTH-1:0] a1,
                             input logic signed [COEF_WIDTH-1:0] a2);
        send_cmd(op_set_b0, b0);
        send_cmd(op_set_b1, b1);
        send_cmd(op_set_b2, b2);
        send_cmd(op_set_a1, a1);
        send_cmd(op_set_a2, a2);
        m_b0 = b0;
        m_b1 = b1;
        m_b2 = b2;
        m_a1 = a1;
        m_a2 = a2;
    endtask

    task automatic set_bypass(input logic on);
        logic signed [COEF_WIDTH-1:0] data;
        data = '0;
        data[0] = on;
        send_cmd(op_bypass, data);
        m_bypass = on;
    endtask

    // clear pulse acts one cycle after the command
    task automatic clear_history();
        send_cmd(op_clear, '0);
        @(posedge clk);
        #1;
        m_x1 = 0;
        m_x2 = 0;
        m_y1 = 0;
        m_y2 = 0;
    endtask

    // one sample through the DUT, optionally with a dropped strobe at cycle drop_at
    task automatic run_sample(input logic signed [SAMPLE_WIDTH-1:0] x, input int drop_at,
                              output logic signed [SAMPLE_WIDTH-1:0] got);
        logic signed [SAMPLE_WIDTH-1:0] exp_y;
        logic                           exp_sat;
        int                             k;
        logic                           seen;
        time                            t_accept;
        predict(x, exp_y, exp_sat);
        in_valid = 1'b1;
        in_sample = x;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        t_accept = $time;
        check_flag("busy after accept", busy, 1'b1);
        k = 0;
        seen = 1'b0;
        while (!seen && k < LATENCY_LIMIT) begin
            if (k + 1 == drop_at) begin
                in_valid = 1'b1;
                in_sample = DROP_SAMPLE;
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            k++;
            check_flag("overrun", overrun, k == drop_at);
            seen = out_valid;
            if (k < LATENCY) begin
                check_flag("busy in flight", busy, 1'b1);
            end
        end
        if (!seen) begin
            abort_run($sformatf("no out_valid within %0d cycles of the sample accepted at %0t ns",
                                LATENCY_LIMIT, t_accept));
        end
        check_latency("output latency", k, LATENCY);
        check_flag("busy after output", busy, 1'b0);
        check_sample("out_sample", out_sample, exp_y);
        check_flag("out_sat", out_sat, exp_sat);
        got = out_sample;
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_flag("busy while idle", busy, 1'b0);
            check_flag("overrun while idle", overrun, 1'b0);
            check_flag("out_valid while idle", out_valid, 1'b0);
        end
    endtask

    task automatic bypass_passthrough();
        logic signed [SAMPLE_WIDTH-1:0] x;
        logic signed [SAMPLE_WIDTH-1:0] got;
        int                             i;
        set_bypass(1'b1);
        for (i = 0; i < N_BYPASS; i++) begin
            x = random_sample();
            run_sample(x, 0, got);
            check_sample("bypass output", got, x);
        end
        set_bypass(1'b0);
    endtask

    // impulse of one in Q1.14 returns the taps themselves
    task automatic fir_impulse();
        logic signed [SAMPLE_WIDTH-1:0] taps [3];
        logic signed [SAMPLE_WIDTH-1:0] got;
        int                             i;
        taps[0] = 16'sd12345;
        taps[1] = -16'sd7001;
        taps[2] = 16'sd2999;
        clear_history();
        set_coefs(taps[0], taps[1], taps[2], '0, '0);
        for (i = 0; i < N_FIR; i++) begin
            run_sample((i == 0) ? 16'sd16384 : 16'sd0, 0, got);
            check_sample("FIR tap", got, (i < 3) ? taps[i] : 16'sd0);
        end
    endtask

    task automatic iir_random();
        logic signed [SAMPLE_WIDTH-1:0] x;
        logic signed [SAMPLE_WIDTH-1:0] got;
        int                             set;
        int                             i;
        clear_history();
        // gain of two pushes both rails
        set_coefs(18'sd32768, '0, '0, '0, '0);
        run_sample(16'sd20000, 0, got);
        run_sample(-16'sd20000, 0, got);
        for (set = 0; set < 2; set++) begin
            set_coefs(random_coef(set == 1), random_coef(set == 1), random_coef(set == 1),
                      random_coef(set == 1), random_coef(set == 1));
            for (i = 0; i < N_IIR; i++) begin
                if (i % 5 == 4) begin
                    x = (i % 10 == 4) ? SAMPLE_MAX : SAMPLE_MIN;
                end else begin
                    x = random_sample();
                end
                run_sample(x, 0, got);
            end
        end
    endtask

    task automatic clear_repeat();
        logic signed [SAMPLE_WIDTH-1:0] first_resp [N_IMPULSE];
        logic signed [SAMPLE_WIDTH-1:0] got;
        int                             i;
        // stable poles, so the response decays
        set_coefs(18'sd8192, 18'sd4096, -18'sd2048, -18'sd9830, 18'sd3277);
        clear_history();
        for (i = 0; i < N_IMPULSE; i++) begin
            run_sample((i == 0) ? 16'sd16384 : 16'sd0, 0, first_resp[i]);
        end
        for (i = 0; i < N_MIX; i++) begin
            run_sample(random_sample(), 0, got);
        end
        clear_history();
        for (i = 0; i < N_IMPULSE; i++) begin
            run_sample((i == 0) ? 16'sd16384 : 16'sd0, 0, got);
            check_sample("response after clear", got, first_resp[i]);
        end
    endtask

    task automatic overrun_drop();
        logic signed [SAMPLE_WIDTH-1:0] got;
        int                             i;
        clear_history();
        run_sample(random_sample(), 3, got);
        // the dropped strobe must not produce a second result
        watch_idle(10);
        for (i = 1; i < N_OVERRUN; i++) begin
            run_sample(random_sample(), 0, got);
        end
    endtask

    initial begin
        seed = 32'hc541;
        clk = 1'b0;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = op_nop;
        cmd_data = '0;
        in_valid = 1'b0;
        in_sample = '0;
        m_b0 = 0;
        m_b1 = 0;
        m_b2 = 0;
        m_a1 = 0;
        m_a2 = 0;
        m_x1 = 0;
        m_x2 = 0;
        m_y1 = 0;
        m_y2 = 0;
        m_bypass = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        watch_idle(6);
        bypass_passthrough();
        fir_impulse();
        iir_random();
        clear_repeat();
        overrun_drop();
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("watchdog expired after %0d ns before the tests finished",
                            WATCHDOG_NS));
    end

endmodule

// ==== verif/biquad_checker.sv ====
`timescale 1ns/100ps

module biquad_checker (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic busy,
    input logic out_valid,
    input logic overrun
);

    // fixed decode to result latency
    localparam int LATENCY = 7;

    // an accepted sample always produces a result
    // out_valid rises after the seventh edge, so it is sampled one edge later
    property accept_to_output;
        @(posedge clk) disable iff (reset)
        (in_valid && !busy) |-> ##(LATENCY + 1) out_valid;
    endproperty

    property single_output_pulse;
        @(posedge clk) disable iff (reset)
        out_valid |=> !out_valid;
    endproperty

    // overrun only follows a dropped strobe
    property overrun_cause;
        @(posedge clk) disable iff (reset)
        overrun |-> $past(in_valid && busy);
    endproperty

    property idle_in_reset;
        @(posedge clk)
        reset |=> !busy;
    endproperty

    a_latency: assert property (accept_to_output)
        else $error("out_valid missing %0d cycles after an accepted sample", LATENCY);
    a_pulse: assert property (single_output_pulse)
        else $error("out_valid high on two consecutive cycles");
    a_overrun: assert property (overrun_cause)
        else $error("overrun without in_valid during busy");
    a_reset: assert property (idle_in_reset)
        else $error("busy high while reset is asserted");

endmodule

// ==== design/biquad_top.sv ====
`timescale 1ns/100ps

module biquad_top
    import filter_pkg::*, ctrl_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cmd_valid,
    input  cmd_op_t                        cmd_op,
    input  logic signed [COEF_WIDTH-1:0]   cmd_data,
    input  logic                           in_valid,
    input  logic signed [SAMPLE_WIDTH-1:0] in_sample,
    output logic signed [SAMPLE_WIDTH-1:0] out_sample,
    output logic                           out_valid,
    output logic                           out_sat,
    output logic                           busy,
    output logic                           overrun
);

    logic signed [COEF_WIDTH-1:0] b0;
    logic signed [COEF_WIDTH-1:0] b1;
    logic signed [COEF_WIDTH-1:0] b2;
    logic signed [COEF_WIDTH-1:0] a1;
    logic signed [COEF_WIDTH-1:0] a2;
    logic                         bypass;
    logic                         clear_state;
    logic signed [ACC_WIDTH-1:0]  acc;
    logic                         acc_valid;

    coef_decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_data    (cmd_data),
        .b0          (b0),
        .b1          (b1),
        .b2          (b2),
        .a1          (a1),
        .a2          (a2),
        .bypass      (bypass),
        .clear_state (clear_state)
    );

    // output sample loops back as y history
    biquad_execute i_execute (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_sample   (in_sample),
        .b0          (b0),
        .b1          (b1),
        .b2          (b2),
        .a1          (a1),
        .a2          (a2),
        .bypass      (bypass),
        .clear_state (clear_state),
        .y_valid     (out_valid),
        .y_sample    (out_sample),
        .acc         (acc),
        .acc_valid   (acc_valid),
        .busy        (busy),
        .overrun     (overrun)
    );

    result_round i_result (
        .clk        (clk),
        .reset      (reset),
        .acc        (acc),
        .acc_valid  (acc_valid),
        .out_sample (out_sample),
        .out_valid  (out_valid),
        .out_sat    (out_sat)
    );

endmodule

// ==== design/result_round.sv ====
`timescale 1ns/100ps

module result_round
    import filter_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic signed [ACC_WIDTH-1:0]    acc,
    input  logic                           acc_valid,
    output logic signed [SAMPLE_WIDTH-1:0] out_sample,
    output logic                           out_valid,
    output logic                           out_sat
);

    logic signed [ACC_WIDTH-1:0] rounded;
    logic signed [ACC_WIDTH-1:0] shifted;
    logic                        over_hi;
    logic                        over_lo;

    // round half up, then drop the coefficient fraction
    assign rounded = acc + (ACC_WIDTH'(1) <<< (COEF_FRAC - 1));
    assign shifted = rounded >>> COEF_FRAC;

    assign over_hi = (shifted > SAMPLE_MAX);
    assign over_lo = (shifted < SAMPLE_MIN);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            if (over_hi) begin
                out_sample <= SAMPLE_MAX;
            end else if (over_lo) begin
                out_sample <= SAMPLE_MIN;
            end else begin
                out_sample <= shifted[SAMPLE_WIDTH-1:0];
            end
            out_sat <= over_hi || over_lo;
        end
    end

endmodule

// ==== design/biquad_execute.sv ====
`timescale 1ns/100ps

module biquad_execute
    import filter_pkg::*, ctrl_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic signed [SAMPLE_WIDTH-1:0] in_sample,
    input  logic signed [COEF_WIDTH-1:0]   b0,
    input  logic signed [COEF_WIDTH-1:0]   b1,
    input  logic signed [COEF_WIDTH-1:0]   b2,
    input  logic signed [COEF_WIDTH-1:0]   a1,
    input  logic signed [COEF_WIDTH-1:0]   a2,
    input  logic                           bypass,
    input  logic                           clear_state,
    input  logic                           y_valid,
    input  logic signed [SAMPLE_WIDTH-1:0] y_sample,
    output logic signed [ACC_WIDTH-1:0]    acc,
    output logic                           acc_valid,
    output logic                           busy,
    output logic                           overrun
);

    exec_state_t state;

    // x[n], x[n-1], x[n-2]
    logic signed [SAMPLE_WIDTH-1:0] x0;
    logic signed [SAMPLE_WIDTH-1:0] x1;
    logic signed [SAMPLE_WIDTH-1:0] x2;
    // y[n-1], y[n-2]
    logic signed [SAMPLE_WIDTH-1:0] y1;
    logic signed [SAMPLE_WIDTH-1:0] y2;

    logic signed [COEF_WIDTH-1:0]    mul_coef;
    logic signed [SAMPLE_WIDTH-1:0]  mul_data;
    logic signed [PRODUCT_WIDTH-1:0] prod;

    // one sample in flight at a time
    assign busy = (state != st_idle);

    // operand select for the shared multiplier
    always_comb begin
        mul_coef = '0;
        mul_data = '0;
        case (state)
            st_mac_b0: begin
                mul_coef = b0;
                mul_data = x0;
            end
            st_mac_b1: begin
                mul_coef = b1;
                mul_data = x1;
            end
            st_mac_b2: begin
                mul_coef = b2;
                mul_data = x2;
            end
            st_mac_a1: begin
                mul_coef = a1;
                mul_data = y1;
            end
            st_mac_a2: begin
                mul_coef = a2;
                mul_data = y2;
            end
            default: begin
            end
        endcase
    end

    // product register, accumulated one state later
    always_ff @(posedge clk) begin
        prod <= mul_coef * mul_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            acc       <= '0;
            acc_valid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            acc_valid <= 1'b0;
            // a strobe during busy is dropped
            overrun   <= in_valid && busy;
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        state <= st_mac_b0;
                    end
                end
                st_mac_b0: begin
                    state <= st_mac_b1;
                end
                st_mac_b1: begin
                    acc   <= ACC_WIDTH'(prod);
                    state <= st_mac_b2;
                end
                st_mac_b2: begin
                    acc   <= acc + prod;
                    state <= st_mac_a1;
                end
                st_mac_a1: begin
                    acc   <= acc + prod;
                    state <= st_mac_a2;
                end
                st_mac_a2: begin
                    // feedback terms are subtracted
                    acc   <= acc - prod;
                    state <= st_wait;
                end
                st_wait: begin
                    if (!acc_valid) begin
                        // last feedback term, or the scaled input in bypass
                        if (bypass) begin
                            acc <= ACC_WIDTH'(x0) <<< COEF_FRAC;
                        end else begin
                            acc <= acc - prod;
                        end
                        acc_valid <= 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // filter history
    always_ff @(posedge clk) begin
        if (reset || clear_state) begin
            x0 <= '0;
            x1 <= '0;
            x2 <= '0;
            y1 <= '0;
            y2 <= '0;
        end else begin
            if (state == st_idle && in_valid) begin
                x0 <= in_sample;
            end
            // x shifts as the sample retires
            if (state == st_wait && acc_valid) begin
                x1 <= x0;
                x2 <= x1;
            end
            // saturated output returns as y history
            if (y_valid) begin
                y1 <= y_sample;
                y2 <= y1;
            end
        end
    end

endmodule

// ==== design/coef_decode.sv ====
`timescale 1ns/100ps

module coef_decode
    import filter_pkg::*, ctrl_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cmd_valid,
    input  cmd_op_t                      cmd_op,
    input  logic signed [COEF_WIDTH-1:0] cmd_data,
    output logic signed [COEF_WIDTH-1:0] b0,
    output logic signed [COEF_WIDTH-1:0] b1,
    output logic signed [COEF_WIDTH-1:0] b2,
    output logic signed [COEF_WIDTH-1:0] a1,
    output logic signed [COEF_WIDTH-1:0] a2,
    output logic                         bypass,
    output logic                         clear_state
);

    always_ff @(posedge clk) begin
        if (reset) begin
            b0          <= '0;
            b1          <= '0;
            b2          <= '0;
            a1          <= '0;
            a2          <= '0;
            bypass      <= 1'b0;
            clear_state <= 1'b0;
        end else begin
            // clear is a single-cycle pulse
            clear_state <= 1'b0;
            if (cmd_valid) begin
                case (cmd_op)
                    op_set_b0: begin
                        b0 <= cmd_data;
                    end
                    op_set_b1: begin
                        b1 <= cmd_data;
                    end
                    op_set_b2: begin
                        b2 <= cmd_data;
                    end
                    op_set_a1: begin
                        a1 <= cmd_data;
                    end
                    op_set_a2: begin
                        a2 <= cmd_data;
                    end
                    op_clear: begin
                        clear_state <= 1'b1;
                    end
                    op_bypass: begin
                        bypass <= cmd_data[0];
                    end
                    default: begin
                        // op_nop leaves everything as is
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

    // command port opcodes
    typedef enum logic [2:0] {
        op_nop    = 3'd0,
        op_set_b0 = 3'd1,
        op_set_b1 = 3'd2,
        op_set_b2 = 3'd3,
        op_set_a1 = 3'd4,
        op_set_a2 = 3'd5,
        op_clear  = 3'd6,
        // bit 0 of cmd_data gives the bypass value
        op_bypass = 3'd7
    } cmd_op_t;

    // execute stage sequencing, one multiply per mac state
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_mac_b0 = 3'd1,
        st_mac_b1 = 3'd2,
        st_mac_b2 = 3'd3,
        st_mac_a1 = 3'd4,
        st_mac_a2 = 3'd5,
        st_wait   = 3'd6
    } exec_state_t;

endpackage

// ==== design/filter_pkg.sv ====
package filter_pkg;

    // signed input and output samples
    localparam int SAMPLE_WIDTH = 16;

    // signed coefficients, Q3.14
    localparam int COEF_WIDTH = 18;
    localparam int COEF_FRAC = 14;

    // one multiplier result
    localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + COEF_WIDTH;

    // headroom for five accumulated products
    localparam int ACC_WIDTH = 40;

    // saturation limits of an output sample
    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

endpackage
